//--- compile.f
+incdir+.
dcache_pkg.sv
replay_fifo.sv
dcache_tag_mem.sv
dcache_data_mem.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

//--- dcache_ctrl.sv
/*
 * Cache control. Evaluates the item in stage 1, returns the result
 * or a rollback in stage 2, and runs the single miss/write engine.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
  (input  wire                                 clk_i
  ,input  wire                                 reset_i

  ,input  wire                                 issue_v_i
  ,input  wire dcache_pkg::dcache_op_e         issue_op_i
  ,input  wire [dcache_pkg::ADDR_WIDTH-1:0]    issue_addr_i
  ,input  wire [dcache_pkg::DWORD_WIDTH-1:0]   issue_data_i
  ,output logic                                issue_yumi_o

  ,input  wire                                 hit_i
  ,input  wire [dcache_pkg::DWORD_WIDTH-1:0]   rd_data_i

  ,output logic                                commit_o
  ,output logic                                roll_o

  ,output logic                                fill_v_o
  ,output logic [dcache_pkg::ADDR_WIDTH-1:0]   fill_addr_o
  ,output logic                                wr_v_o
  ,output logic [dcache_pkg::ADDR_WIDTH-1:0]   wr_addr_o
  ,output logic [dcache_pkg::DWORD_WIDTH-1:0]  wr_data_o

  ,output logic                                v_o
  ,output logic [dcache_pkg::DWORD_WIDTH-1:0]  data_o

  ,output logic                                mem_fwd_v_o
  ,output dcache_pkg::mem_op_e                 mem_fwd_op_o
  ,output logic [dcache_pkg::ADDR_WIDTH-1:0]   mem_fwd_addr_o
  ,output logic [dcache_pkg::DWORD_WIDTH-1:0]  mem_fwd_data_o
  ,input  wire                                 mem_fwd_ready_and_i

  ,input  wire                                 mem_rev_v_i
  ,input  wire [dcache_pkg::DWORD_WIDTH-1:0]   mem_rev_data_i
  ,output logic                                mem_rev_ready_and_o
  );

  dcache_pkg::miss_state_e state_r;
  dcache_pkg::miss_state_e state_n;

  logic                               s1_v_r;
  dcache_pkg::dcache_op_e             s1_op_r;
  logic [dcache_pkg::ADDR_WIDTH-1:0]  s1_addr_r;
  logic [dcache_pkg::DWORD_WIDTH-1:0] s1_data_r;

  logic                               s2_v_r;
  logic                               s2_ok_r;
  logic [dcache_pkg::DWORD_WIDTH-1:0] s2_data_r;

  logic [dcache_pkg::ADDR_WIDTH-1:0]  eng_addr_r;
  logic [dcache_pkg::DWORD_WIDTH-1:0] eng_data_r;

  logic eng_ready;
  logic s1_live;
  logic s1_is_ld;
  logic ld_hit;
  logic ld_miss_start;
  logic st_accept;
  logic st_hit_wr;

  assign eng_ready = (state_r == dcache_pkg::e_ready);

  // Stage 2 result
  assign commit_o = s2_v_r & s2_ok_r;
  assign roll_o   = s2_v_r & ~s2_ok_r;
  assign v_o      = commit_o;
  assign data_o   = s2_data_r;

  // No issue on a rewind, nor while memory work is pending
  assign issue_yumi_o = issue_v_i & eng_ready & ~roll_o;

  // Stage 1 decision, squashed by a rollback from stage 2
  assign s1_live       = s1_v_r & ~roll_o;
  assign s1_is_ld      = (s1_op_r == dcache_pkg::e_op_ld);
  assign ld_hit        = s1_live & s1_is_ld & hit_i;
  assign ld_miss_start = s1_live & s1_is_ld & ~hit_i & eng_ready;
  assign st_accept     = s1_live & ~s1_is_ld & eng_ready;
  assign st_hit_wr     = st_accept & hit_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      s1_v_r <= 1'b0;
      s2_v_r <= 1'b0;
    end
    else
    begin
      s1_v_r <= issue_yumi_o;
      s2_v_r <= s1_live;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (issue_yumi_o)
    begin
      s1_op_r   <= issue_op_i;
      s1_addr_r <= issue_addr_i;
      s1_data_r <= issue_data_i;
    end
    s2_ok_r   <= ld_hit | st_accept;
    s2_data_r <= rd_data_i;
    if (ld_miss_start | st_accept)
    begin
      eng_addr_r <= s1_addr_r;
      eng_data_r <= s1_data_r;
    end
  end

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      dcache_pkg::e_ready:
      begin
        if (ld_miss_start)
          state_n = dcache_pkg::e_send_rd;
        else if (st_accept)
          state_n = dcache_pkg::e_send_wr;
      end
      dcache_pkg::e_send_rd:
        if (mem_fwd_ready_and_i)
          state_n = dcache_pkg::e_wait_rev;
      dcache_pkg::e_wait_rev:
        if (mem_rev_v_i)
          state_n = dcache_pkg::e_ready;
      dcache_pkg::e_send_wr:
        if (mem_fwd_ready_and_i)
          state_n = dcache_pkg::e_ready;
      default:
        state_n = dcache_pkg::e_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= dcache_pkg::e_ready;
    else
      state_r <= state_n;
  end

  assign mem_fwd_v_o    = (state_r == dcache_pkg::e_send_rd)
                        | (state_r == dcache_pkg::e_send_wr);
  assign mem_fwd_op_o   = (state_r == dcache_pkg::e_send_wr)
                        ? dcache_pkg::e_mem_wr : dcache_pkg::e_mem_rd;
  assign mem_fwd_addr_o = eng_addr_r;
  assign mem_fwd_data_o = eng_data_r;

  assign mem_rev_ready_and_o = (state_r == dcache_pkg::e_wait_rev);

  // Single-beat fill of the missed line
  assign fill_v_o    = mem_rev_ready_and_o & mem_rev_v_i;
  assign fill_addr_o = eng_addr_r;

  // Store hits and fills never overlap, fills need e_wait_rev
  assign wr_v_o    = st_hit_wr | fill_v_o;
  assign wr_addr_o = fill_v_o ? eng_addr_r : s1_addr_r;
  assign wr_data_o = fill_v_o ? mem_rev_data_i : s1_data_r;

  fwd_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_fwd_v_o && !mem_fwd_ready_and_i |=> mem_fwd_v_o
      && $stable(mem_fwd_op_o) && $stable(mem_fwd_addr_o) && $stable(mem_fwd_data_o));

  // Nothing may read the arrays while a fill is on its way
  fill_quiet_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == dcache_pkg::e_wait_rev) |-> !s1_v_r && !s2_v_r);

endmodule

`default_nettype wire

//--- dcache_data_mem.sv
/*
 * Dword data array with a registered read port and one write port.
 * Writes to the line being read are forwarded to the read data.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_data_mem
  #(parameter int SETS_P = 16)
  (input  wire                                 clk_i

  ,input  wire                                 rd_v_i
  ,input  wire [dcache_pkg::ADDR_WIDTH-1:0]    rd_addr_i
  ,output logic [dcache_pkg::DWORD_WIDTH-1:0]  rd_data_o

  ,input  wire                                 wr_v_i
  ,input  wire [dcache_pkg::ADDR_WIDTH-1:0]    wr_addr_i
  ,input  wire [dcache_pkg::DWORD_WIDTH-1:0]   wr_data_i
  );

  localparam int IDX_W = $clog2(SETS_P);

  logic [dcache_pkg::DWORD_WIDTH-1:0] data_mem [SETS_P];
  logic [IDX_W-1:0]                   rd_idx;
  logic [IDX_W-1:0]                   wr_idx;
  logic                               wr_fwd;

  assign rd_idx = rd_addr_i[IDX_W-1:0];
  assign wr_idx = wr_addr_i[IDX_W-1:0];
  assign wr_fwd = wr_v_i & (wr_idx == rd_idx);

  always_ff @(posedge clk_i)
  begin
    if (wr_v_i)
      data_mem[wr_idx] <= wr_data_i;
    // Write-first so a store in stage 1 reaches the next load
    if (rd_v_i)
      rd_data_o <= wr_fwd ? wr_data_i : data_mem[rd_idx];
  end

endmodule

`default_nettype wire

//--- dcache_pkg.sv
/*
 * Shared widths and encodings for the write-through data cache.
 * Every design file refers to these names with the package scope.
 */

`default_nettype none

package dcache_pkg;

  // Dword address, one cache line per dword
  localparam int ADDR_WIDTH = 16;
  localparam int DWORD_WIDTH = 64;

  // Request opcodes seen by the cache
  typedef enum logic
  {
    e_op_ld = 1'b0,
    e_op_sd = 1'b1
  } dcache_op_e;

  // Memory forward opcodes
  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Miss and write-through engine
  typedef enum logic [1:0]
  {
    e_ready    = 2'd0,
    e_send_rd  = 2'd1,
    e_wait_rev = 2'd2,
    e_send_wr  = 2'd3
  } miss_state_e;

endpackage

`default_nettype wire

//--- dcache_tag_mem.sv
/*
 * Tag and valid array of the direct-mapped cache. Lookup is
 * registered, the hit compare happens one cycle after the read.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_tag_mem
  #(parameter int SETS_P = 16)
  (input  wire                                clk_i
  ,input  wire                                reset_i

  ,input  wire                                rd_v_i
  ,input  wire [dcache_pkg::ADDR_WIDTH-1:0]   rd_addr_i

  ,input  wire                                fill_v_i
  ,input  wire [dcache_pkg::ADDR_WIDTH-1:0]   fill_addr_i

  ,output logic                               hit_o
  );

  localparam int IDX_W = $clog2(SETS_P);
  localparam int TAG_W = dcache_pkg::ADDR_WIDTH - IDX_W;

  logic [TAG_W-1:0]  tag_mem [SETS_P];
  logic [SETS_P-1:0] valid_r;

  logic [IDX_W-1:0]  rd_idx;
  logic [IDX_W-1:0]  fill_idx;
  logic [TAG_W-1:0]  rd_tag;
  logic [TAG_W-1:0]  fill_tag;
  logic              fill_bypass;

  logic [TAG_W-1:0]  look_tag_r;
  logic [TAG_W-1:0]  req_tag_r;
  logic              look_valid_r;

  assign rd_idx   = rd_addr_i[IDX_W-1:0];
  assign rd_tag   = rd_addr_i[dcache_pkg::ADDR_WIDTH-1:IDX_W];
  assign fill_idx = fill_addr_i[IDX_W-1:0];
  assign fill_tag = fill_addr_i[dcache_pkg::ADDR_WIDTH-1:IDX_W];

  // A fill to the line being looked up is visible to that lookup
  assign fill_bypass = fill_v_i & (fill_idx == rd_idx);

  always_ff @(posedge clk_i)
  begin
    if (fill_v_i)
      tag_mem[fill_idx] <= fill_tag;
    if (rd_v_i)
    begin
      look_tag_r <= fill_bypass ? fill_tag : tag_mem[rd_idx];
      req_tag_r  <= rd_tag;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r      <= '0;
      look_valid_r <= 1'b0;
    end
    else
    begin
      if (fill_v_i)
        valid_r[fill_idx] <= 1'b1;
      if (rd_v_i)
        look_valid_r <= fill_bypass | valid_r[rd_idx];
    end
  end

  assign hit_o = look_valid_r & (look_tag_r == req_tag_r);

endmodule

`default_nettype wire

//--- dcache_top.sv
/*
 * Data cache top level. Connects the replay FIFO, the tag and data
 * arrays and the control, and sets the cache and queue sizes.
 */

`timescale 1ns/1ps
`default_nettype none

module dcache_top
  #(parameter int SETS_P = 16
  ,parameter int FIFO_ELS_P = 8)
  (input  wire                                 clk_i
  ,input  wire                                 reset_i

  ,input  wire                                 v_i
  ,input  wire dcache_pkg::dcache_op_e         op_i
  ,input  wire [dcache_pkg::ADDR_WIDTH-1:0]    addr_i
  ,input  wire [dcache_pkg::DWORD_WIDTH-1:0]   st_data_i
  ,output logic                                ready_o

  ,output logic                                v_o
  ,output logic [dcache_pkg::DWORD_WIDTH-1:0]  data_o

  ,output logic                                mem_fwd_v_o
  ,output dcache_pkg::mem_op_e                 mem_fwd_op_o
  ,output logic [dcache_pkg::ADDR_WIDTH-1:0]   mem_fwd_addr_o
  ,output logic [dcache_pkg::DWORD_WIDTH-1:0]  mem_fwd_data_o
  ,input  wire                                 mem_fwd_ready_and_i

  ,input  wire                                 mem_rev_v_i
  ,input  wire [dcache_pkg::DWORD_WIDTH-1:0]   mem_rev_data_i
  ,output logic                                mem_rev_ready_and_o
  );

  // Replay FIFO to cache
  logic                               issue_v;
  dcache_pkg::dcache_op_e             issue_op;
  logic [dcache_pkg::ADDR_WIDTH-1:0]  issue_addr;
  logic [dcache_pkg::DWORD_WIDTH-1:0] issue_data;
  logic                               issue_yumi;
  logic                               commit;
  logic                               roll;

  // Arrays to and from control
  logic                               hit;
  logic [dcache_pkg::DWORD_WIDTH-1:0] rd_data;
  logic                               fill_v;
  logic [dcache_pkg::ADDR_WIDTH-1:0]  fill_addr;
  logic                               wr_v;
  logic [dcache_pkg::ADDR_WIDTH-1:0]  wr_addr;
  logic [dcache_pkg::DWORD_WIDTH-1:0] wr_data;

  replay_fifo
   #(.FIFO_ELS_P(FIFO_ELS_P))
   fifo
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.enq_v_i(v_i)
    ,.enq_op_i(op_i)
    ,.enq_addr_i(addr_i)
    ,.enq_data_i(st_data_i)
    ,.ready_o(ready_o)
    ,.issue_v_o(issue_v)
    ,.issue_op_o(issue_op)
    ,.issue_addr_o(issue_addr)
    ,.issue_data_o(issue_data)
    ,.issue_yumi_i(issue_yumi)
    ,.commit_i(commit)
    ,.roll_i(roll)
    );

  dcache_tag_mem
   #(.SETS_P(SETS_P))
   tag_mem
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.rd_v_i(issue_yumi)
    ,.rd_addr_i(issue_addr)
    ,.fill_v_i(fill_v)
    ,.fill_addr_i(fill_addr)
    ,.hit_o(hit)
    );

  dcache_data_mem
   #(.SETS_P(SETS_P))
   data_mem
    (.clk_i(clk_i)
    ,.rd_v_i(issue_yumi)
    ,.rd_addr_i(issue_addr)
    ,.rd_data_o(rd_data)
    ,.wr_v_i(wr_v)
    ,.wr_addr_i(wr_addr)
    ,.wr_data_i(wr_data)
    );

  dcache_ctrl
   ctrl
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.issue_v_i(issue_v)
    ,.issue_op_i(issue_op)
    ,.issue_addr_i(issue_addr)
    ,.issue_data_i(issue_data)
    ,.issue_yumi_o(issue_yumi)
    ,.hit_i(hit)
    ,.rd_data_i(rd_data)
    ,.commit_o(commit)
    ,.roll_o(roll)
    ,.fill_v_o(fill_v)
    ,.fill_addr_o(fill_addr)
    ,.wr_v_o(wr_v)
    ,.wr_addr_o(wr_addr)
    ,.wr_data_o(wr_data)
    ,.v_o(v_o)
    ,.data_o(data_o)
    ,.mem_fwd_v_o(mem_fwd_v_o)
    ,.mem_fwd_op_o(mem_fwd_op_o)
    ,.mem_fwd_addr_o(mem_fwd_addr_o)
    ,.mem_fwd_data_o(mem_fwd_data_o)
    ,.mem_fwd_ready_and_i(mem_fwd_ready_and_i)
    ,.mem_rev_v_i(mem_rev_v_i)
    ,.mem_rev_data_i(mem_rev_data_i)
    ,.mem_rev_ready_and_o(mem_rev_ready_and_o)
    );

endmodule

`default_nettype wire

//--- replay_fifo.sv
/*
 * Replay queue in front of the cache. Entries stay until committed,
 * and a roll sends the issue pointer back to the oldest entry.
 */

`timescale 1ns/1ps
`default_nettype none

module replay_fifo
  #(parameter int FIFO_ELS_P = 8)
  (input  wire                                    clk_i
  ,input  wire                                    reset_i

  ,input  wire                                    enq_v_i
  ,input  wire dcache_pkg::dcache_op_e            enq_op_i
  ,input  wire [dcache_pkg::ADDR_WIDTH-1:0]       enq_addr_i
  ,input  wire [dcache_pkg::DWORD_WIDTH-1:0]      enq_data_i
  ,output logic                                   ready_o

  ,output logic                                   issue_v_o
  ,output dcache_pkg::dcache_op_e                 issue_op_o
  ,output logic [dcache_pkg::ADDR_WIDTH-1:0]      issue_addr_o
  ,output logic [dcache_pkg::DWORD_WIDTH-1:0]     issue_data_o
  ,input  wire                                    issue_yumi_i

  ,input  wire                                    commit_i
  ,input  wire                                    roll_i
  );

  // Depth must be a power of two, extra bit tells full from empty
  localparam int PTR_W = $clog2(FIFO_ELS_P);

  logic [PTR_W:0] wptr_r;
  logic [PTR_W:0] iptr_r;
  logic [PTR_W:0] cptr_r;
  logic [PTR_W:0] occupancy;
  logic           full;
  logic           enq;

  dcache_pkg::dcache_op_e              op_mem   [FIFO_ELS_P];
  logic [dcache_pkg::ADDR_WIDTH-1:0]   addr_mem [FIFO_ELS_P];
  logic [dcache_pkg::DWORD_WIDTH-1:0]  data_mem [FIFO_ELS_P];

  assign occupancy = wptr_r - cptr_r;
  assign full = (wptr_r[PTR_W-1:0] == cptr_r[PTR_W-1:0])
              && (wptr_r[PTR_W] != cptr_r[PTR_W]);
  assign ready_o = ~full;
  assign enq = enq_v_i & ~full;

  // Head of the not-yet-issued part
  assign issue_v_o    = (iptr_r != wptr_r);
  assign issue_op_o   = op_mem[iptr_r[PTR_W-1:0]];
  assign issue_addr_o = addr_mem[iptr_r[PTR_W-1:0]];
  assign issue_data_o = data_mem[iptr_r[PTR_W-1:0]];

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      op_mem[wptr_r[PTR_W-1:0]]   <= enq_op_i;
      addr_mem[wptr_r[PTR_W-1:0]] <= enq_addr_i;
      data_mem[wptr_r[PTR_W-1:0]] <= enq_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r <= '0;
      iptr_r <= '0;
      cptr_r <= '0;
    end
    else
    begin
      if (enq)
        wptr_r <= wptr_r + (PTR_W+1)'(1);
      // Rewind wins over issue, ctrl never does both
      if (roll_i)
        iptr_r <= cptr_r;
      else if (issue_yumi_i)
        iptr_r <= iptr_r + (PTR_W+1)'(1);
      if (commit_i)
        cptr_r <= cptr_r + (PTR_W+1)'(1);
    end
  end

  // Only issued entries can be committed
  commit_issued_a: assert property (@(posedge clk_i) disable iff (reset_i)
    commit_i |-> (cptr_r != iptr_r));

  // Issue pointer stays between the oldest entry and the write pointer
  issue_in_range_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (iptr_r - cptr_r) <= occupancy);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_dcache \
  -Mdir obj_dir -o sim_tb_dcache \
  && ./obj_dir/sim_tb_dcache > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }

cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log && exit 0 || exit 1

//--- tb_init_pattern.svh
/*
 * Initial memory contents for the testbench, shared by the memory
 * model and the reference model. Included inside a module body.
 */

// Every address bit lands in each of the four fields
function automatic logic [63:0] init_dword(input logic [15:0] a);
  return {a ^ 16'h5a5a, ~a, {a[7:0], a[15:8]}, a * 16'h0097};
endfunction

//--- tb_dcache.sv
/*
 * Testbench for the write-through data cache. Applies a table of
 * loads and stores and checks completions and memory traffic.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

  localparam int SETS = 16;
  localparam int FIFO_ELS = 8;
  localparam int MAX_ENTRIES = 64;
  localparam int N_TESTS = 6;

  `include "tb_init_pattern.svh"

  logic                                 clk;
  logic                                 reset;
  logic                                 v_i;
  dcache_pkg::dcache_op_e               op_i;
  logic [dcache_pkg::ADDR_WIDTH-1:0]    addr_i;
  logic [dcache_pkg::DWORD_WIDTH-1:0]   st_data_i;
  logic                                 ready;
  logic                                 v_o;
  logic [dcache_pkg::DWORD_WIDTH-1:0]   data_o;
  logic                                 fwd_v;
  dcache_pkg::mem_op_e                  fwd_op;
  logic [dcache_pkg::ADDR_WIDTH-1:0]    fwd_addr;
  logic [dcache_pkg::DWORD_WIDTH-1:0]   fwd_data;
  logic                                 fwd_ready;
  logic                                 rev_v;
  logic [dcache_pkg::DWORD_WIDTH-1:0]   rev_data;
  logic                                 rev_ready;

  // Stimulus table and expected traffic
  dcache_pkg::dcache_op_e tbl_op   [MAX_ENTRIES];
  logic [15:0]            tbl_addr [MAX_ENTRIES];
  logic [63:0]            tbl_data [MAX_ENTRIES];
  logic [63:0]            tbl_exp  [MAX_ENTRIES];
  int                     n_entries;
  int                     test_end [N_TESTS];
  int                     mem_end  [N_TESTS];
  string                  test_name [N_TESTS];

  logic [63:0]            ref_mem [logic [15:0]];
  logic [15:0]            tag_model [SETS];
  logic                   tag_valid [SETS];

  dcache_pkg::dcache_op_e exp_op_q [$];
  logic [63:0]            exp_data_q [$];
  dcache_pkg::mem_op_e    mem_op_q [$];
  logic [15:0]            mem_addr_q [$];
  logic [63:0]            mem_data_q [$];

  int errors;
  int done_count;
  int mem_seen;
  bit ready_low_seen;
  bit table_ready;

  dcache_top
   #(.SETS_P(SETS), .FIFO_ELS_P(FIFO_ELS))
   uut
    (.clk_i(clk), .reset_i(reset)
    ,.v_i(v_i), .op_i(op_i), .addr_i(addr_i), .st_data_i(st_data_i), .ready_o(ready)
    ,.v_o(v_o), .data_o(data_o)
    ,.mem_fwd_v_o(fwd_v), .mem_fwd_op_o(fwd_op), .mem_fwd_addr_o(fwd_addr)
    ,.mem_fwd_data_o(fwd_data), .mem_fwd_ready_and_i(fwd_ready)
    ,.mem_rev_v_i(rev_v), .mem_rev_data_i(rev_data), .mem_rev_ready_and_o(rev_ready)
    );

  tb_mem_model mem
    (.clk_i(clk), .reset_i(reset)
    ,.fwd_v_i(fwd_v), .fwd_op_i(fwd_op), .fwd_addr_i(fwd_addr), .fwd_data_i(fwd_data)
    ,.fwd_ready_and_o(fwd_ready)
    ,.rev_v_o(rev_v), .rev_data_o(rev_data), .rev_ready_and_i(rev_ready)
    );

  always #5 clk = ~clk;

  // Appends one request, predicts its load data and its memory traffic
  task automatic add_entry(input dcache_pkg::dcache_op_e op, input logic [15:0] addr,
                           input logic [63:0] data);
    int idx;
    idx = int'(addr) % SETS;
    tbl_op[n_entries] = op;
    tbl_addr[n_entries] = addr;
    tbl_data[n_entries] = (op == dcache_pkg::e_op_sd) ? data : '0;
    if (op == dcache_pkg::e_op_sd)
    begin
      ref_mem[addr] = data;
      tbl_exp[n_entries] = data;
      mem_op_q.push_back(dcache_pkg::e_mem_wr);
      mem_addr_q.push_back(addr);
      mem_data_q.push_back(data);
    end
    else
    begin
      tbl_exp[n_entries] = ref_mem.exists(addr) ? ref_mem[addr] : init_dword(addr);
      // Miss when the line holds another address
      if (!tag_valid[idx] || tag_model[idx] != addr)
      begin
        tag_valid[idx] = 1'b1;
        tag_model[idx] = addr;
        mem_op_q.push_back(dcache_pkg::e_mem_rd);
        mem_addr_q.push_back(addr);
        mem_data_q.push_back('0);
      end
    end
    exp_op_q.push_back(op);
    exp_data_q.push_back(tbl_exp[n_entries]);
    n_entries++;
  endtask

  task automatic close_test(input int t, input string name);
    test_end[t] = n_entries;
    mem_end[t] = mem_op_q.size();
    test_name[t] = name;
  endtask

  task automatic build_table();
    for (int s = 0; s < SETS; s++)
      tag_valid[s] = 1'b0;
    add_entry(dcache_pkg::e_op_ld, 16'h0010, '0);
    close_test(0, "cold load miss");
    add_entry(dcache_pkg::e_op_ld, 16'h0010, '0);
    add_entry(dcache_pkg::e_op_ld, 16'h0010, '0);
    close_test(1, "repeated load hit");
    add_entry(dcache_pkg::e_op_sd, 16'h0010, 64'hdead_beef_0bad_f00d);
    add_entry(dcache_pkg::e_op_ld, 16'h0010, '0);
    add_entry(dcache_pkg::e_op_sd, 16'h0123, 64'h1234_5678_9abc_def0);
    add_entry(dcache_pkg::e_op_ld, 16'h0123, '0);
    close_test(2, "store hit and miss");
    add_entry(dcache_pkg::e_op_ld, 16'h0200, '0);
    add_entry(dcache_pkg::e_op_ld, 16'h0010, '0);
    add_entry(dcache_pkg::e_op_ld, 16'h0200, '0);
    close_test(3, "index conflict");
    for (int i = 0; i < 16; i++)
      add_entry(($urandom & 1) ? dcache_pkg::e_op_sd : dcache_pkg::e_op_ld,
                16'h0400 + 16'(($urandom % 2) * 16) + 16'($urandom % 4),
                {$urandom, $urandom});
    close_test(4, "random back-to-back");
    for (int i = 0; i < 12; i++)
      add_entry(dcache_pkg::e_op_ld, 16'h2000 + 16'(i), '0);
    close_test(5, "fifo full");
  endtask

  task automatic check_dword(input logic [dcache_pkg::DWORD_WIDTH-1:0] got,
                             input logic [dcache_pkg::DWORD_WIDTH-1:0] exp,
                             input int idx);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: request %0d load data %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_mem(input dcache_pkg::mem_op_e got_op,
                           input logic [dcache_pkg::ADDR_WIDTH-1:0] got_addr,
                           input logic [dcache_pkg::DWORD_WIDTH-1:0] got_data,
                           input dcache_pkg::mem_op_e exp_op,
                           input logic [dcache_pkg::ADDR_WIDTH-1:0] exp_addr,
                           input logic [dcache_pkg::DWORD_WIDTH-1:0] exp_data);
    // Read requests carry no meaningful data
    if (got_op !== exp_op || got_addr !== exp_addr
        || (exp_op == dcache_pkg::e_mem_wr && got_data !== exp_data))
    begin
      errors++;
      $display("FAILED %0t: memory %s %h data %h, expected %s %h data %h", $time,
               got_op.name(), got_addr, got_data, exp_op.name(), exp_addr, exp_data);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin : monitor
    dcache_pkg::dcache_op_e op;
    logic [63:0]            exp;
    if (!reset)
    begin
      if (!ready)
        ready_low_seen = 1'b1;
      if (v_o && exp_op_q.size() == 0)
      begin
        errors++;
        $display("A completion arrived at %0t with no request outstanding", $time);
      end
      else if (v_o)
      begin
        op = exp_op_q.pop_front();
        exp = exp_data_q.pop_front();
        if (op == dcache_pkg::e_op_ld)
          check_dword(data_o, exp, done_count);
        done_count++;
      end
      if (fwd_v && fwd_ready && mem_op_q.size() == 0)
      begin
        errors++;
        $display("An unexpected memory request was sent at %0t", $time);
      end
      else if (fwd_v && fwd_ready)
      begin
        check_mem(fwd_op, fwd_addr, fwd_data, mem_op_q.pop_front(),
                  mem_addr_q.pop_front(), mem_data_q.pop_front());
        mem_seen++;
      end
    end
  end

  // Holds the request until the FIFO takes it
  task automatic send_entry(input int i);
    v_i = 1'b1;
    op_i = tbl_op[i];
    addr_i = tbl_addr[i];
    st_data_i = tbl_data[i];
    while (!ready)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    v_i = 1'b0;
  endtask

  initial
  begin : watchdog
    wait (table_ready);
    #(200 * n_entries * 10);
    $display("Timeout: the cache did not finish all requests in time");
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin : main
    int first;
    int start_errors;
    clk = 1'b0;
    reset = 1'b1;
    v_i = 1'b0;
    op_i = dcache_pkg::e_op_ld;
    addr_i = '0;
    st_data_i = '0;
    void'($urandom(32'h4b7d_1cb1));
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // Idle outputs straight out of reset
    if (v_o || fwd_v || rev_ready || !ready)
    begin
      errors++;
      $display("The cache outputs were not idle right after reset");
    end
    first = 0;
    for (int t = 0; t < N_TESTS; t++)
    begin
      start_errors = errors;
      ready_low_seen = 1'b0;
      for (int i = first; i < test_end[t]; i++)
        send_entry(i);
      wait (done_count == test_end[t] && mem_seen == mem_end[t]);
      @(posedge clk);
      #1;
      if (t == N_TESTS - 1 && !ready_low_seen)
      begin
        errors++;
        $display("ready_o never fell while the FIFO was being filled");
      end
      $display("test %0d %s: %0d errors", t + 1, test_name[t], errors - start_errors);
      first = test_end[t];
    end
    $display("%0d tests, %0d of %0d completions, %0d errors",
             N_TESTS, done_count, n_entries, errors);
    if (errors == 0 && done_count == n_entries)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
/*
 * Behavioral memory for the cache testbench. Sparse storage with
 * random forward back-pressure and a random 0-5 cycle read delay.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
  (input  wire                                 clk_i
  ,input  wire                                 reset_i

  ,input  wire                                 fwd_v_i
  ,input  wire dcache_pkg::mem_op_e            fwd_op_i
  ,input  wire [dcache_pkg::ADDR_WIDTH-1:0]    fwd_addr_i
  ,input  wire [dcache_pkg::DWORD_WIDTH-1:0]   fwd_data_i
  ,output logic                                fwd_ready_and_o

  ,output logic                                rev_v_o
  ,output logic [dcache_pkg::DWORD_WIDTH-1:0]  rev_data_o
  ,input  wire                                 rev_ready_and_i
  );

  `include "tb_init_pattern.svh"

  logic [63:0] mem [logic [15:0]];
  logic        rd_pend;
  logic [15:0] rd_addr;
  int unsigned delay;

  initial
  begin
    fwd_ready_and_o = 1'b0;
    rev_v_o = 1'b0;
    rev_data_o = '0;
    rd_pend = 1'b0;
    rd_addr = '0;
    delay = 0;
  end

  always @(posedge clk_i)
  begin : mem_step
    logic                fwd_fire;
    logic                rev_fire;
    dcache_pkg::mem_op_e op;
    logic [15:0]         addr;
    logic [63:0]         data;
    // Sample the handshake before anything moves
    fwd_fire = fwd_v_i && fwd_ready_and_o;
    rev_fire = rev_v_o && rev_ready_and_i;
    op = fwd_op_i;
    addr = fwd_addr_i;
    data = fwd_data_i;
    #1;
    if (reset_i)
    begin
      fwd_ready_and_o = 1'b0;
      rev_v_o = 1'b0;
      rd_pend = 1'b0;
    end
    else
    begin
      if (fwd_fire && op == dcache_pkg::e_mem_wr)
        mem[addr] = data;
      else if (fwd_fire)
      begin
        rd_pend = 1'b1;
        rd_addr = addr;
        delay = $urandom % 6;
      end
      if (rev_fire)
        rev_v_o = 1'b0;
      if (rd_pend && delay == 0)
      begin
        rev_v_o = 1'b1;
        rev_data_o = mem.exists(rd_addr) ? mem[rd_addr] : init_dword(rd_addr);
        rd_pend = 1'b0;
      end
      else if (rd_pend)
        delay = delay - 1;
      fwd_ready_and_o = ($urandom % 4) != 0;
    end
  end

endmodule

`default_nettype wire
